// ==== id_decode.f ====
+incdir+source
source/id_pkg.sv
source/id_pipe_reg.sv
source/inst_decoder.sv
source/operand_select.sv
source/id_stage.sv
test/id_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f id_decode.f --top-module id_stage_tb -o id_stage_sim

# the simulator stops with a nonzero status on failure, the search below decides
output=$(./obj_dir/id_stage_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== source/id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define XLEN        64
`define INST_W      32
`define REG_ADDR_W  5
`define PC_STEP     4

// rv64i major opcodes
`define OPC_LOAD     7'h03
`define OPC_ARITH_I  7'h13
`define OPC_AUIPC    7'h17
`define OPC_ARITH_IW 7'h1b
`define OPC_STORE    7'h23
`define OPC_ARITH_R  7'h33
`define OPC_LUI      7'h37
`define OPC_ARITH_RW 7'h3b
`define OPC_BRANCH   7'h63
`define OPC_JALR     7'h67
`define OPC_JAL      7'h6f

// funct6/funct7 values
`define F6_SRL   6'h00
`define F6_SRA   6'h10
`define F7_BASE  7'h00
`define F7_ALT   7'h20

// alu one-hot positions
`define ALU_ADD  0
`define ALU_SUB  1
`define ALU_SLT  2
`define ALU_SLTU 3
`define ALU_XOR  4
`define ALU_OR   5
`define ALU_AND  6
`define ALU_SLL  7
`define ALU_SRL  8
`define ALU_SRA  9

// branch/jump one-hot positions
`define BJ_BEQ   0
`define BJ_BNE   1
`define BJ_BLT   2
`define BJ_BGE   3
`define BJ_BLTU  4
`define BJ_BGEU  5
`define BJ_JALR  6
`define BJ_JAL   7

`define ALU_OP_W   10
`define BJ_OP_W    8
`define LOAD_OP_W  7
`define STORE_OP_W 4

// operand and immediate select positions
`define SEL_W      3
`define OP1_RS1    0
`define OP1_PC     1
`define OP1_ZERO   2
`define OP2_RS2    0
`define OP2_IMM    1
`define OP2_STEP   2
`define IMM_SEL_W  5
`define IMM_I      0
`define IMM_S      1
`define IMM_B      2
`define IMM_U      3
`define IMM_J      4
`define JIMM_B     0
`define JIMM_J     1
`define JIMM_I     2

`endif

// ==== source/id_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module id_pipe_reg (
  input  logic          clk,
  input  logic          rst,
  input  logic          if_to_id_valid,
  input  id_pkg::xlen_t if_to_id_pc,
  input  id_pkg::inst_t if_to_id_inst,
  input  logic          ex_allowin,
  input  logic          br_flush,
  output logic          id_allowin,
  output logic          id_valid,
  output id_pkg::xlen_t id_pc,
  output id_pkg::inst_t id_inst
);
  import id_pkg::*;

  logic  valid_r;
  xlen_t pc_r;
  inst_t inst_r;

  // decode never stalls on its own
  assign id_allowin = !valid_r || ex_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
    end else if (id_allowin) begin
      valid_r <= if_to_id_valid;
    end else if (br_flush) begin
      // stalled and redirected, drop the held instruction
      valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_to_id_valid && id_allowin) begin
      pc_r   <= if_to_id_pc;
      inst_r <= if_to_id_inst;
    end
  end

  assign id_valid = valid_r;
  assign id_pc    = pc_r;
  // empty stage decodes as all zeros
  assign id_inst  = inst_r & {`INST_W{valid_r}};

endmodule

`default_nettype wire

// ==== source/id_pkg.sv ====
`default_nettype none

`include "id_macros.svh"

package id_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`INST_W-1:0]     inst_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // one-hot control vectors
  typedef logic [`ALU_OP_W-1:0]   alu_op_t;
  typedef logic [`BJ_OP_W-1:0]    bj_op_t;
  typedef logic [`LOAD_OP_W-1:0]  load_op_t;
  typedef logic [`STORE_OP_W-1:0] store_op_t;

  // operand source selects
  typedef logic [`SEL_W-1:0]      op1_sel_t;
  typedef logic [`SEL_W-1:0]      op2_sel_t;
  typedef logic [`IMM_SEL_W-1:0]  imm_sel_t;
  typedef logic [`SEL_W-1:0]      jmp_imm_sel_t;

  typedef struct packed {
    alu_op_t   alu_op;
    bj_op_t    bj_op;
    load_op_t  load_op;
    store_op_t store_op;
    logic      is_word;
    logic      mem_rd;
    logic      mem_wr;
    logic      reg_wr;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
  } id_ctrl_t;

  typedef struct packed {
    op1_sel_t     op1_sel;
    op2_sel_t     op2_sel;
    imm_sel_t     imm_sel;
    // B, J or I format for the jump target offset
    jmp_imm_sel_t jmp_imm_sel;
  } opnd_sel_t;

  // bundle handed to execute
  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    jmp_imm;
    id_ctrl_t ctrl;
  } id_to_ex_t;

endpackage

`default_nettype wire

// ==== source/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                if_to_id_valid,
  input  id_pkg::xlen_t       if_to_id_pc,
  input  id_pkg::inst_t       if_to_id_inst,
  output logic                id_allowin,
  output logic                id_to_ex_valid,
  output id_pkg::id_to_ex_t   id_to_ex_bus,
  input  logic                ex_allowin,
  input  logic                br_flush,
  output id_pkg::reg_addr_t   rs1_addr,
  output id_pkg::reg_addr_t   rs2_addr,
  input  id_pkg::xlen_t       rs1_data,
  input  id_pkg::xlen_t       rs2_data
);
  import id_pkg::*;

  logic      id_valid;
  xlen_t     id_pc;
  inst_t     id_inst;
  id_ctrl_t  ctrl;
  opnd_sel_t opnd_sel;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     jmp_imm;

  id_pipe_reg u_pipe_reg (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .ex_allowin     (ex_allowin),
    .br_flush       (br_flush),
    .id_allowin     (id_allowin),
    .id_valid       (id_valid),
    .id_pc          (id_pc),
    .id_inst        (id_inst)
  );

  inst_decoder u_decoder (
    .id_inst  (id_inst),
    .ctrl     (ctrl),
    .opnd_sel (opnd_sel)
  );

  operand_select u_opnd_sel (
    .id_inst  (id_inst),
    .id_pc    (id_pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .opnd_sel (opnd_sel),
    .op1      (op1),
    .op2      (op2),
    .jmp_imm  (jmp_imm)
  );

  // register file read ports
  assign rs1_addr = ctrl.rs1_addr;
  assign rs2_addr = ctrl.rs2_addr;

  // a redirect kills the instruction in decode at once
  assign id_to_ex_valid = id_valid & ~br_flush;

  assign id_to_ex_bus = '{
    pc:       id_pc,
    inst:     id_inst,
    op1:      op1,
    op2:      op2,
    rs1_data: rs1_data,
    rs2_data: rs2_data,
    jmp_imm:  jmp_imm,
    ctrl:     ctrl
  };

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module inst_decoder (
  input  id_pkg::inst_t     id_inst,
  output id_pkg::id_ctrl_t  ctrl,
  output id_pkg::opnd_sel_t opnd_sel
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;
  logic [6:0] funct7;
  logic [7:0] f3;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;

  assign opcode = id_inst[6:0];
  assign funct3 = id_inst[14:12];
  assign funct6 = id_inst[31:26];
  assign funct7 = id_inst[31:25];
  assign rd     = id_inst[11:7];
  assign rs1    = id_inst[19:15];
  assign rs2    = id_inst[24:20];
  assign f3     = 8'b1 << funct3;

  // opcode classes
  wire is_load     = (opcode == `OPC_LOAD);
  wire is_arith_i  = (opcode == `OPC_ARITH_I);
  wire is_auipc    = (opcode == `OPC_AUIPC);
  wire is_arith_iw = (opcode == `OPC_ARITH_IW);
  wire is_store    = (opcode == `OPC_STORE);
  wire is_arith_r  = (opcode == `OPC_ARITH_R);
  wire is_lui      = (opcode == `OPC_LUI);
  wire is_arith_rw = (opcode == `OPC_ARITH_RW);
  wire is_branch   = (opcode == `OPC_BRANCH);
  wire is_jalr     = (opcode == `OPC_JALR) & f3[0];
  wire is_jal      = (opcode == `OPC_JAL);

  wire f6_srl = (funct6 == `F6_SRL);
  wire f6_sra = (funct6 == `F6_SRA);
  wire f7_base = (funct7 == `F7_BASE);
  wire f7_alt  = (funct7 == `F7_ALT);

  // register-immediate, 64-bit
  wire inst_addi  = is_arith_i & f3[0];
  wire inst_slli  = is_arith_i & f3[1] & f6_srl;
  wire inst_slti  = is_arith_i & f3[2];
  wire inst_sltiu = is_arith_i & f3[3];
  wire inst_xori  = is_arith_i & f3[4];
  wire inst_srli  = is_arith_i & f3[5] & f6_srl;
  wire inst_srai  = is_arith_i & f3[5] & f6_sra;
  wire inst_ori   = is_arith_i & f3[6];
  wire inst_andi  = is_arith_i & f3[7];

  // register-immediate, word
  wire inst_addiw = is_arith_iw & f3[0];
  wire inst_slliw = is_arith_iw & f3[1] & f7_base;
  wire inst_srliw = is_arith_iw & f3[5] & f6_srl;
  wire inst_sraiw = is_arith_iw & f3[5] & f6_sra;

  // register-register, 64-bit
  wire inst_add  = is_arith_r & f3[0] & f7_base;
  wire inst_sub  = is_arith_r & f3[0] & f7_alt;
  wire inst_sll  = is_arith_r & f3[1];
  wire inst_slt  = is_arith_r & f3[2];
  wire inst_sltu = is_arith_r & f3[3];
  wire inst_xor  = is_arith_r & f3[4];
  wire inst_srl  = is_arith_r & f3[5] & f7_base;
  wire inst_sra  = is_arith_r & f3[5] & f7_alt;
  wire inst_or   = is_arith_r & f3[6];
  wire inst_and  = is_arith_r & f3[7];

  // register-register, word
  wire inst_addw = is_arith_rw & f3[0] & f7_base;
  wire inst_subw = is_arith_rw & f3[0] & f7_alt;
  wire inst_sllw = is_arith_rw & f3[1];
  wire inst_srlw = is_arith_rw & f3[5] & f7_base;
  wire inst_sraw = is_arith_rw & f3[5] & f7_alt;

  wire inst_beq  = is_branch & f3[0];
  wire inst_bne  = is_branch & f3[1];
  wire inst_blt  = is_branch & f3[4];
  wire inst_bge  = is_branch & f3[5];
  wire inst_bltu = is_branch & f3[6];
  wire inst_bgeu = is_branch & f3[7];

  alu_op_t   alu_op;
  bj_op_t    bj_op;
  load_op_t  load_op;
  store_op_t store_op;
  op1_sel_t  op1_sel;
  op2_sel_t  op2_sel;
  imm_sel_t  imm_sel;
  jmp_imm_sel_t jmp_imm_sel;
  logic      use_rs1;
  logic      use_rs2;
  logic      reg_wr;

  // address generation and link values go through the adder
  assign alu_op[`ALU_ADD]  = inst_add | inst_addi | inst_addw | inst_addiw
                           | is_auipc | is_lui | is_load | is_store
                           | is_jal | is_jalr;
  // branches compare through sub plus one condition bit
  assign alu_op[`ALU_SUB]  = inst_sub | inst_subw | is_branch;
  assign alu_op[`ALU_SLT]  = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[`ALU_SLTU] = inst_sltu | inst_sltiu | inst_bltu | inst_bgeu;
  assign alu_op[`ALU_XOR]  = inst_xor | inst_xori | inst_beq | inst_bne;
  assign alu_op[`ALU_OR]   = inst_or | inst_ori;
  assign alu_op[`ALU_AND]  = inst_and | inst_andi;
  assign alu_op[`ALU_SLL]  = inst_sll | inst_slli | inst_sllw | inst_slliw;
  assign alu_op[`ALU_SRL]  = inst_srl | inst_srli | inst_srlw | inst_srliw;
  assign alu_op[`ALU_SRA]  = inst_sra | inst_srai | inst_sraw | inst_sraiw;

  assign bj_op = {is_jal, is_jalr, inst_bgeu, inst_bltu,
                  inst_bge, inst_blt, inst_bne, inst_beq};

  // lb lh lw ld lbu lhu lwu from bit 0 up
  assign load_op  = {7{is_load}} & f3[6:0];
  assign store_op = {4{is_store}} & f3[3:0];

  assign op1_sel[`OP1_RS1]  = is_load | is_arith_i | is_arith_iw | is_store
                            | is_arith_r | is_arith_rw | is_branch;
  assign op1_sel[`OP1_PC]   = is_auipc | is_jalr | is_jal;
  assign op1_sel[`OP1_ZERO] = is_lui;

  assign op2_sel[`OP2_RS2]  = is_arith_r | is_arith_rw | is_branch;
  assign op2_sel[`OP2_IMM]  = is_load | is_arith_i | is_arith_iw | is_store
                            | is_auipc | is_lui;
  assign op2_sel[`OP2_STEP] = is_jal | is_jalr;

  assign imm_sel[`IMM_I] = is_load | is_arith_i | is_arith_iw | is_jalr;
  assign imm_sel[`IMM_S] = is_store;
  assign imm_sel[`IMM_B] = is_branch;
  assign imm_sel[`IMM_U] = is_auipc | is_lui;
  assign imm_sel[`IMM_J] = is_jal;

  assign jmp_imm_sel[`JIMM_B] = is_branch;
  assign jmp_imm_sel[`JIMM_J] = is_jal;
  assign jmp_imm_sel[`JIMM_I] = is_jalr;

  // jalr reads rs1 for its target even though op1 is the pc
  assign use_rs1 = op1_sel[`OP1_RS1] | is_jalr;
  assign use_rs2 = is_arith_r | is_arith_rw | is_store | is_branch;
  assign reg_wr  = is_load | is_arith_i | is_auipc | is_arith_iw | is_arith_r
                 | is_lui | is_arith_rw | is_jalr | is_jal;

  assign ctrl = '{
    alu_op:   alu_op,
    bj_op:    bj_op,
    load_op:  load_op,
    store_op: store_op,
    is_word:  is_arith_iw | is_arith_rw,
    mem_rd:   is_load,
    mem_wr:   is_store,
    reg_wr:   reg_wr,
    rd_addr:  reg_wr ? rd : '0,
    rs1_addr: use_rs1 ? rs1 : '0,
    rs2_addr: use_rs2 ? rs2 : '0
  };

  assign opnd_sel = '{
    op1_sel:     op1_sel,
    op2_sel:     op2_sel,
    imm_sel:     imm_sel,
    jmp_imm_sel: jmp_imm_sel
  };

endmodule

`default_nettype wire

// ==== source/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module operand_select (
  input  id_pkg::inst_t     id_inst,
  input  id_pkg::xlen_t     id_pc,
  input  id_pkg::xlen_t     rs1_data,
  input  id_pkg::xlen_t     rs2_data,
  input  id_pkg::opnd_sel_t opnd_sel,
  output id_pkg::xlen_t     op1,
  output id_pkg::xlen_t     op2,
  output id_pkg::xlen_t     jmp_imm
);
  import id_pkg::*;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  xlen_t imm;

  // sign-extended immediates per format
  assign imm_i = {{(`XLEN-12){id_inst[31]}}, id_inst[31:20]};
  assign imm_s = {{(`XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b = {{(`XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7],
                  id_inst[30:25], id_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){id_inst[31]}}, id_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12],
                  id_inst[20], id_inst[30:21], 1'b0};

  always_comb begin
    case (1'b1)
      opnd_sel.imm_sel[`IMM_I]: imm = imm_i;
      opnd_sel.imm_sel[`IMM_S]: imm = imm_s;
      opnd_sel.imm_sel[`IMM_B]: imm = imm_b;
      opnd_sel.imm_sel[`IMM_U]: imm = imm_u;
      opnd_sel.imm_sel[`IMM_J]: imm = imm_j;
      default:                  imm = '0;
    endcase
  end

  always_comb begin
    case (1'b1)
      opnd_sel.op1_sel[`OP1_RS1]:  op1 = rs1_data;
      opnd_sel.op1_sel[`OP1_PC]:   op1 = id_pc;
      opnd_sel.op1_sel[`OP1_ZERO]: op1 = '0;
      default:                     op1 = '0;
    endcase
  end

  always_comb begin
    case (1'b1)
      opnd_sel.op2_sel[`OP2_RS2]:  op2 = rs2_data;
      opnd_sel.op2_sel[`OP2_IMM]:  op2 = imm;
      // link value for jal/jalr
      opnd_sel.op2_sel[`OP2_STEP]: op2 = xlen_t'(`PC_STEP);
      default:                     op2 = '0;
    endcase
  end

  always_comb begin
    case (1'b1)
      opnd_sel.jmp_imm_sel[`JIMM_B]: jmp_imm = imm_b;
      opnd_sel.jmp_imm_sel[`JIMM_J]: jmp_imm = imm_j;
      opnd_sel.jmp_imm_sel[`JIMM_I]: jmp_imm = imm_i;
      default:                       jmp_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== test/id_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
  import id_pkg::*;

  localparam int    TIMEOUT_CYCLES = 20;
  localparam xlen_t RF_KEY         = 64'h3c5a_96f0_0ff0_a55a;

  // expected result of one table row
  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    jmp_imm;
    id_ctrl_t ctrl;
  } row_t;

  logic      clk;
  logic      rst;
  logic      if_to_id_valid;
  xlen_t     if_to_id_pc;
  inst_t     if_to_id_inst;
  logic      id_allowin;
  logic      id_to_ex_valid;
  id_to_ex_t id_to_ex_bus;
  logic      ex_allowin;
  logic      br_flush;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  row_t  rows[$];
  string names[$];

  id_stage UUT (
    .clk            (clk),
    .rst            (rst),
    .if_to_id_valid (if_to_id_valid),
    .if_to_id_pc    (if_to_id_pc),
    .if_to_id_inst  (if_to_id_inst),
    .id_allowin     (id_allowin),
    .id_to_ex_valid (id_to_ex_valid),
    .id_to_ex_bus   (id_to_ex_bus),
    .ex_allowin     (ex_allowin),
    .br_flush       (br_flush),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data)
  );

  // register file model, address in every byte
  function automatic xlen_t rf_value(input reg_addr_t addr);
    return {8{3'b000, addr}} ^ RF_KEY;
  endfunction

  assign rs1_data = rf_value(rs1_addr);
  assign rs2_data = rf_value(rs2_addr);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_reg_addr(input string name, input reg_addr_t exp,
                                input reg_addr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bj_op(input string name, input bj_op_t exp, input bj_op_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_mem_op(input string name, input load_op_t exp_ld,
                              input store_op_t exp_st, input load_op_t act_ld,
                              input store_op_t act_st);
    if (act_ld !== exp_ld || act_st !== exp_st) begin
      $display("** Error %s: expected load %b store %b, actual load %b store %b",
               name, exp_ld, exp_st, act_ld, act_st);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bundle(input string name, input id_to_ex_t exp,
                              input id_to_ex_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  // flags are {is_word, mem_rd, mem_wr, reg_wr}
  function automatic void add_row(input string name, input xlen_t pc, input inst_t inst,
                                  input xlen_t op1, input xlen_t op2, input xlen_t jmp_imm,
                                  input alu_op_t alu_op, input bj_op_t bj_op,
                                  input load_op_t load_op, input store_op_t store_op,
                                  input logic [3:0] flags, input reg_addr_t rd,
                                  input reg_addr_t rs1, input reg_addr_t rs2);
    row_t r;
    r.pc             = pc;
    r.inst           = inst;
    r.op1            = op1;
    r.op2            = op2;
    r.jmp_imm        = jmp_imm;
    r.ctrl.alu_op    = alu_op;
    r.ctrl.bj_op     = bj_op;
    r.ctrl.load_op   = load_op;
    r.ctrl.store_op  = store_op;
    r.ctrl.is_word   = flags[3];
    r.ctrl.mem_rd    = flags[2];
    r.ctrl.mem_wr    = flags[1];
    r.ctrl.reg_wr    = flags[0];
    r.ctrl.rd_addr   = rd;
    r.ctrl.rs1_addr  = rs1;
    r.ctrl.rs2_addr  = rs2;
    rows.push_back(r);
    names.push_back(name);
  endfunction

  task automatic wait_allowin(input string name);
    int n;
    n = 0;
    while (id_allowin !== 1'b1) begin
      if (n >= TIMEOUT_CYCLES) begin
        $display("%s: timed out waiting for id_allowin", name);
        stop_run();
      end
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic wait_valid(input string name, output int cycles);
    int n;
    n = 0;
    while (id_to_ex_valid !== 1'b1) begin
      if (n >= TIMEOUT_CYCLES) begin
        $display("%s: timed out waiting for id_to_ex_valid", name);
        stop_run();
      end
      @(posedge clk);
      #2;
      n++;
    end
    cycles = n;
  endtask

  task automatic run_row(input int i);
    row_t  r;
    string name;
    int    waited;
    r    = rows[i];
    name = names[i];
    wait_allowin(name);
    if_to_id_valid = 1'b1;
    if_to_id_pc    = r.pc;
    if_to_id_inst  = r.inst;
    @(posedge clk);
    #2;
    if_to_id_valid = 1'b0;
    #1;
    wait_valid(name, waited);
    if (waited != 0) begin
      $display("%s: id_to_ex_valid did not rise right after the accepting edge", name);
      stop_run();
    end
    check_xlen({name, " pc"}, r.pc, id_to_ex_bus.pc);
    check_inst({name, " inst"}, r.inst, id_to_ex_bus.inst);
    check_xlen({name, " op1"}, r.op1, id_to_ex_bus.op1);
    check_xlen({name, " op2"}, r.op2, id_to_ex_bus.op2);
    check_xlen({name, " rs1_data"}, rf_value(r.ctrl.rs1_addr), id_to_ex_bus.rs1_data);
    check_xlen({name, " rs2_data"}, rf_value(r.ctrl.rs2_addr), id_to_ex_bus.rs2_data);
    check_xlen({name, " jmp_imm"}, r.jmp_imm, id_to_ex_bus.jmp_imm);
    check_alu_op({name, " alu_op"}, r.ctrl.alu_op, id_to_ex_bus.ctrl.alu_op);
    check_bj_op({name, " bj_op"}, r.ctrl.bj_op, id_to_ex_bus.ctrl.bj_op);
    check_mem_op({name, " mem_op"}, r.ctrl.load_op, r.ctrl.store_op,
                 id_to_ex_bus.ctrl.load_op, id_to_ex_bus.ctrl.store_op);
    check_bit({name, " is_word"}, r.ctrl.is_word, id_to_ex_bus.ctrl.is_word);
    check_bit({name, " mem_rd"}, r.ctrl.mem_rd, id_to_ex_bus.ctrl.mem_rd);
    check_bit({name, " mem_wr"}, r.ctrl.mem_wr, id_to_ex_bus.ctrl.mem_wr);
    check_bit({name, " reg_wr"}, r.ctrl.reg_wr, id_to_ex_bus.ctrl.reg_wr);
    check_reg_addr({name, " rd_addr"}, r.ctrl.rd_addr, id_to_ex_bus.ctrl.rd_addr);
    check_reg_addr({name, " rs1_addr"}, r.ctrl.rs1_addr, id_to_ex_bus.ctrl.rs1_addr);
    check_reg_addr({name, " rs2_addr"}, r.ctrl.rs2_addr, id_to_ex_bus.ctrl.rs2_addr);
    check_reg_addr({name, " rs1 port"}, r.ctrl.rs1_addr, rs1_addr);
    check_reg_addr({name, " rs2 port"}, r.ctrl.rs2_addr, rs2_addr);
  endtask

  task automatic stall_and_flush();
    id_to_ex_t   exp;
    int unsigned stall_len;
    int          waited;
    // the add row decoded at another pc
    exp.pc       = 64'h8000_2000;
    exp.inst     = rows[0].inst;
    exp.op1      = rows[0].op1;
    exp.op2      = rows[0].op2;
    exp.rs1_data = rf_value(rows[0].ctrl.rs1_addr);
    exp.rs2_data = rf_value(rows[0].ctrl.rs2_addr);
    exp.jmp_imm  = rows[0].jmp_imm;
    exp.ctrl     = rows[0].ctrl;
    wait_allowin("stall");
    if_to_id_valid = 1'b1;
    if_to_id_pc    = exp.pc;
    if_to_id_inst  = exp.inst;
    @(posedge clk);
    #2;
    // execute stalls while a second instruction waits on the fetch side
    ex_allowin    = 1'b0;
    if_to_id_pc   = 64'h8000_2004;
    if_to_id_inst = rows[1].inst;
    #1;
    wait_valid("stall", waited);
    check_bit("stall allowin", 1'b0, id_allowin);
    check_bundle("stall bundle", exp, id_to_ex_bus);
    stall_len = $urandom_range(5, 1);
    repeat (stall_len) begin
      @(posedge clk);
      #3;
      check_bit("stall allowin held", 1'b0, id_allowin);
      check_bit("stall valid held", 1'b1, id_to_ex_valid);
      check_bundle("stall bundle held", exp, id_to_ex_bus);
    end
    br_flush = 1'b1;
    #1;
    check_bit("flush masks valid", 1'b0, id_to_ex_valid);
    @(posedge clk);
    #2;
    br_flush       = 1'b0;
    if_to_id_valid = 1'b0;
    #1;
    // stalled flush leaves the stage empty
    check_bit("flush empties stage", 1'b0, id_to_ex_valid);
    check_bit("allowin after flush", 1'b1, id_allowin);
    ex_allowin = 1'b1;
  endtask

  initial begin
    rst            = 1'b1;
    if_to_id_valid = 1'b0;
    if_to_id_pc    = '0;
    if_to_id_inst  = '0;
    ex_allowin     = 1'b1;
    br_flush       = 1'b0;
    void'($urandom(32'hc6336db9));

    add_row("add", 64'h8000_0000, 32'h002081b3, rf_value(5'd1), rf_value(5'd2), 64'd0,
            10'h001, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd3, 5'd1, 5'd2);
    add_row("sub", 64'h8000_0004, 32'h407302b3, rf_value(5'd6), rf_value(5'd7), 64'd0,
            10'h002, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd5, 5'd6, 5'd7);
    add_row("addi", 64'h8000_0008, 32'hffb58513, rf_value(5'd11), 64'hffff_ffff_ffff_fffb,
            64'd0, 10'h001, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd10, 5'd11, 5'd0);
    add_row("slli", 64'h8000_000c, 32'h00d21213, rf_value(5'd4), 64'd13, 64'd0,
            10'h080, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd4, 5'd4, 5'd0);
    add_row("srai", 64'h8000_0010, 32'h4214d413, rf_value(5'd9), 64'h421, 64'd0,
            10'h200, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd8, 5'd9, 5'd0);
    add_row("addw", 64'h8000_0014, 32'h00e6863b, rf_value(5'd13), rf_value(5'd14), 64'd0,
            10'h001, 8'h00, 7'h00, 4'h0, 4'b1001, 5'd12, 5'd13, 5'd14);
    add_row("sraiw", 64'h8000_0018, 32'h4078579b, rf_value(5'd16), 64'h407, 64'd0,
            10'h200, 8'h00, 7'h00, 4'h0, 4'b1001, 5'd15, 5'd16, 5'd0);
    add_row("sltu", 64'h8000_001c, 32'h013938b3, rf_value(5'd18), rf_value(5'd19), 64'd0,
            10'h008, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd17, 5'd18, 5'd19);
    add_row("xori", 64'h8000_0020, 32'hf00aca13, rf_value(5'd21), 64'hffff_ffff_ffff_ff00,
            64'd0, 10'h010, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd20, 5'd21, 5'd0);
    add_row("and", 64'h8000_0024, 32'h018bfb33, rf_value(5'd23), rf_value(5'd24), 64'd0,
            10'h040, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd22, 5'd23, 5'd24);
    add_row("ld", 64'h8000_0028, 32'hff013283, rf_value(5'd2), 64'hffff_ffff_ffff_fff0,
            64'd0, 10'h001, 8'h00, 7'h08, 4'h0, 4'b0101, 5'd5, 5'd2, 5'd0);
    add_row("lbu", 64'h8000_002c, 32'h0643c303, rf_value(5'd7), 64'd100, 64'd0,
            10'h001, 8'h00, 7'h10, 4'h0, 4'b0101, 5'd6, 5'd7, 5'd0);
    add_row("sw", 64'h8000_0030, 32'h00942a23, rf_value(5'd8), 64'd20, 64'd0,
            10'h001, 8'h00, 7'h00, 4'h4, 4'b0010, 5'd0, 5'd8, 5'd9);
    add_row("sd", 64'h8000_0034, 32'hfea5bc23, rf_value(5'd11), 64'hffff_ffff_ffff_fff8,
            64'd0, 10'h001, 8'h00, 7'h00, 4'h8, 4'b0010, 5'd0, 5'd11, 5'd10);
    add_row("beq", 64'h8000_0038, 32'h00208863, rf_value(5'd1), rf_value(5'd2), 64'd16,
            10'h012, 8'h01, 7'h00, 4'h0, 4'b0000, 5'd0, 5'd1, 5'd2);
    add_row("blt", 64'h8000_003c, 32'hfe41cce3, rf_value(5'd3), rf_value(5'd4),
            64'hffff_ffff_ffff_fff8, 10'h006, 8'h04, 7'h00, 4'h0, 4'b0000, 5'd0, 5'd3, 5'd4);
    add_row("bgeu", 64'h8000_0040, 32'h0062f0e3, rf_value(5'd5), rf_value(5'd6), 64'h800,
            10'h00a, 8'h20, 7'h00, 4'h0, 4'b0000, 5'd0, 5'd5, 5'd6);
    add_row("jal", 64'h8000_0044, 32'h100000ef, 64'h8000_0044, 64'd4, 64'h100,
            10'h001, 8'h80, 7'h00, 4'h0, 4'b0001, 5'd1, 5'd0, 5'd0);
    add_row("jalr", 64'h8000_0048, 32'h00c280e7, 64'h8000_0048, 64'd4, 64'd12,
            10'h001, 8'h40, 7'h00, 4'h0, 4'b0001, 5'd1, 5'd5, 5'd0);
    add_row("lui", 64'h8000_004c, 32'h800003b7, 64'd0, 64'hffff_ffff_8000_0000, 64'd0,
            10'h001, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd7, 5'd0, 5'd0);
    add_row("auipc", 64'h8000_0050, 32'h12345497, 64'h8000_0050, 64'h1234_5000, 64'd0,
            10'h001, 8'h00, 7'h00, 4'h0, 4'b0001, 5'd9, 5'd0, 5'd0);
    add_row("unknown", 64'h8000_0054, 32'hffffffff, 64'd0, 64'd0, 64'd0,
            10'h000, 8'h00, 7'h00, 4'h0, 4'b0000, 5'd0, 5'd0, 5'd0);

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    #1;
    check_bit("reset valid", 1'b0, id_to_ex_valid);
    check_bit("reset allowin", 1'b1, id_allowin);

    for (int i = 0; i < rows.size(); i++) begin
      run_row(i);
    end

    stall_and_flush();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
